// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rs_dispatch
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f files.f
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+testbench
rtl/rs_dispatch_pkg.sv
rtl/rs_dispatch_if.sv
rtl/rs_ex_decoder.sv
rtl/reservation_station.sv
rtl/rs_dispatch_top.sv
testbench/tb_rs_dispatch.sv

// File: rtl/reservation_station.sv
`timescale 1ns/10ps
`default_nettype none

module reservation_station #(
    parameter int  RS_DEPTH  = 8,
    parameter type PAYLOAD_T = rs_dispatch_pkg::muldiv_ctrl_t
) (
    input  wire                                clk,
    input  wire                                reset,
    rs_dispatch_if.station                     disp,
    input  wire                                res_valid,
    input  wire [rs_dispatch_pkg::PTAG_W-1:0]  res_tag,
    input  wire [rs_dispatch_pkg::XLEN-1:0]    res_value,
    output logic                               issue_valid,
    output logic [rs_dispatch_pkg::XLEN-1:0]   issue_op1,
    output logic [rs_dispatch_pkg::XLEN-1:0]   issue_op2,
    output logic [rs_dispatch_pkg::PTAG_W-1:0] issue_rd_tag,
    output logic [rs_dispatch_pkg::INUM_W-1:0] issue_inst_num,
    output PAYLOAD_T                           issue_payload
);

    localparam int SLOT_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0]               busy;
    logic [SLOT_W-1:0]                 age     [RS_DEPTH];   // 0 is the oldest live entry
    logic [1:0]                        rdy     [RS_DEPTH];
    logic [rs_dispatch_pkg::PTAG_W-1:0] tag1   [RS_DEPTH];
    logic [rs_dispatch_pkg::PTAG_W-1:0] tag2   [RS_DEPTH];
    logic [rs_dispatch_pkg::XLEN-1:0]  val1    [RS_DEPTH];
    logic [rs_dispatch_pkg::XLEN-1:0]  val2    [RS_DEPTH];
    logic [rs_dispatch_pkg::PTAG_W-1:0] rd_tag [RS_DEPTH];
    logic [rs_dispatch_pkg::INUM_W-1:0] inum   [RS_DEPTH];
    PAYLOAD_T                          payload [RS_DEPTH];

    logic                              sel_found;
    logic [SLOT_W-1:0]                 sel_idx;
    logic [SLOT_W-1:0]                 sel_age;
    logic                              free_found;
    logic [SLOT_W-1:0]                 free_idx;
    logic [SLOT_W:0]                   occupancy;
    logic [SLOT_W:0]                   new_age;
    logic [1:0]                        in_rdy;
    logic [rs_dispatch_pkg::XLEN-1:0]  in_val1;
    logic [rs_dispatch_pkg::XLEN-1:0]  in_val2;

    // Oldest ready entry, lowest free slot and occupancy in one pass
    always_comb begin
        sel_found  = 1'b0;
        sel_idx    = '0;
        sel_age    = '0;
        free_found = 1'b0;
        free_idx   = '0;
        occupancy  = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (busy[i] && (&rdy[i]) && (!sel_found || age[i] < sel_age)) begin
                sel_found = 1'b1;
                sel_idx   = SLOT_W'(i);
                sel_age   = age[i];
            end
            if (!busy[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = SLOT_W'(i);
            end
            occupancy = occupancy + (SLOT_W + 1)'(busy[i]);
        end
    end

    // Entries left behind after this edge's issue
    assign new_age   = occupancy - (SLOT_W + 1)'(sel_found);
    assign disp.full = &busy;

    // Result arriving in the dispatch cycle is caught on the way in
    always_comb begin
        in_rdy  = disp.src_rdy;
        in_val1 = disp.src1_val;
        in_val2 = disp.src2_val;
        if (res_valid && !disp.src_rdy[0] && disp.src1_tag == res_tag) begin
            in_rdy[0] = 1'b1;
            in_val1   = res_value;
        end
        if (res_valid && !disp.src_rdy[1] && disp.src2_tag == res_tag) begin
            in_rdy[1] = 1'b1;
            in_val2   = res_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= '0;
            age         <= '{default: '0};
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= sel_found;
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (sel_found && busy[i] && age[i] > sel_age) begin
                    age[i] <= age[i] - 1'b1;   // Close the gap left by the issued entry
                end
            end
            if (sel_found) begin
                busy[sel_idx] <= 1'b0;
            end
            if (disp.on) begin
                busy[free_idx] <= 1'b1;
                age[free_idx]  <= new_age[SLOT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (busy[i] && res_valid) begin
                if (!rdy[i][0] && tag1[i] == res_tag) begin
                    val1[i]   <= res_value;
                    rdy[i][0] <= 1'b1;
                end
                if (!rdy[i][1] && tag2[i] == res_tag) begin
                    val2[i]   <= res_value;
                    rdy[i][1] <= 1'b1;
                end
            end
        end
        if (disp.on) begin
            rdy[free_idx]     <= in_rdy;
            tag1[free_idx]    <= disp.src1_tag;
            tag2[free_idx]    <= disp.src2_tag;
            val1[free_idx]    <= in_val1;
            val2[free_idx]    <= in_val2;
            rd_tag[free_idx]  <= disp.rd_tag;
            inum[free_idx]    <= disp.inst_num;
            payload[free_idx] <= disp.payload;
        end
        if (sel_found) begin
            issue_op1      <= val1[sel_idx];
            issue_op2      <= val2[sel_idx];
            issue_rd_tag   <= rd_tag[sel_idx];
            issue_inst_num <= inum[sel_idx];
            issue_payload  <= payload[sel_idx];
        end
    end

    // Rename has to honour the full level
    a_no_disp_when_full : assert property (
        @(posedge clk) disable iff (reset) disp.on |-> !disp.full
    ) else $error("dispatch into a full station");

    // Live entries hold the ages 0 to occupancy - 1
    a_age_in_range : assert property (
        @(posedge clk) disable iff (reset)
        sel_found |-> sel_age < occupancy
    ) else $error("selected entry has an age beyond the occupancy");

endmodule

`default_nettype wire

// File: rtl/rs_dispatch_if.sv
`timescale 1ns/10ps
`default_nettype none

interface rs_dispatch_if #(
    parameter type PAYLOAD_T = logic
) ();

    logic                               on;
    PAYLOAD_T                           payload;
    logic [rs_dispatch_pkg::XLEN-1:0]   src1_val;
    logic [rs_dispatch_pkg::XLEN-1:0]   src2_val;
    logic [rs_dispatch_pkg::PTAG_W-1:0] src1_tag;
    logic [rs_dispatch_pkg::PTAG_W-1:0] src2_tag;
    logic [1:0]                         src_rdy;   // Bit 0 for operand 1
    logic [rs_dispatch_pkg::PTAG_W-1:0] rd_tag;
    logic [rs_dispatch_pkg::INUM_W-1:0] inst_num;
    logic                               full;

    modport decoder (
        output on, payload, src1_val, src2_val, src1_tag, src2_tag,
        output src_rdy, rd_tag, inst_num,
        input  full
    );

    modport station (
        input  on, payload, src1_val, src2_val, src1_tag, src2_tag,
        input  src_rdy, rd_tag, inst_num,
        output full
    );

endinterface

`default_nettype wire

// File: rtl/rs_dispatch_pkg.sv
`default_nettype none

package rs_dispatch_pkg;

    localparam int XLEN    = 32;
    localparam int PTAG_W  = 8;
    localparam int INUM_W  = 32;
    localparam int ALUOP_W = 4;

    localparam logic [6:0] OPC_RTYPE     = 7'b0110011;
    localparam logic [6:0] OPC_NOP       = 7'b0000000;   // Bubble from rename
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    localparam logic [2:0] F3_MUL = 3'b000;
    localparam logic [2:0] F3_DIV = 3'b100;
    localparam logic [2:0] F3_REM = 3'b110;

    // Everything the integer ALU needs besides the operands
    typedef struct packed {
        logic [2:0]         func3;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    immediate;
        logic               mem_to_reg;
        logic               mem_read;
        logic               mem_write;
        logic [ALUOP_W-1:0] alu_op;
        logic               alu_src1;
        logic               alu_src2;
        logic               jump;
        logic               branch;
    } alu_ctrl_t;

    typedef struct packed {
        logic [2:0]      func3;   // Selects MUL, DIV or REM
        logic [XLEN-1:0] pc;
    } muldiv_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/rs_dispatch_top.sv
`timescale 1ns/10ps
`default_nettype none

module rs_dispatch_top #(
    parameter int RS_DEPTH = 8
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire [6:0]                           in_opcode,
    input  wire [2:0]                           in_func3,
    input  wire [6:0]                           in_funct7,
    input  wire [rs_dispatch_pkg::XLEN-1:0]     in_operand1,
    input  wire [rs_dispatch_pkg::XLEN-1:0]     in_operand2,
    input  wire [rs_dispatch_pkg::XLEN-1:0]     in_pc,
    input  wire [rs_dispatch_pkg::XLEN-1:0]     immediate,
    input  wire [rs_dispatch_pkg::INUM_W-1:0]   inst_num,
    input  wire [rs_dispatch_pkg::PTAG_W-1:0]   rd_phy_reg,
    input  wire [rs_dispatch_pkg::PTAG_W-1:0]   operand1_phy,
    input  wire [rs_dispatch_pkg::PTAG_W-1:0]   operand2_phy,
    input  wire [1:0]                           valid,
    input  wire                                 mem_to_reg,
    input  wire                                 mem_read,
    input  wire                                 mem_write,
    input  wire [rs_dispatch_pkg::ALUOP_W-1:0]  alu_op,
    input  wire                                 alu_src1,
    input  wire                                 alu_src2,
    input  wire                                 jump,
    input  wire                                 branch,
    input  wire                                 res_valid,
    input  wire [rs_dispatch_pkg::PTAG_W-1:0]   res_tag,
    input  wire [rs_dispatch_pkg::XLEN-1:0]     res_value,
    output logic                                add_full,
    output logic                                mul_full,
    output logic                                div_full,
    output logic                                add_issue_valid,
    output logic [rs_dispatch_pkg::XLEN-1:0]    add_issue_op1,
    output logic [rs_dispatch_pkg::XLEN-1:0]    add_issue_op2,
    output logic [rs_dispatch_pkg::PTAG_W-1:0]  add_issue_rd_tag,
    output logic [rs_dispatch_pkg::INUM_W-1:0]  add_issue_inst_num,
    output rs_dispatch_pkg::alu_ctrl_t          add_issue_ctrl,
    output logic                                mul_issue_valid,
    output logic [rs_dispatch_pkg::XLEN-1:0]    mul_issue_op1,
    output logic [rs_dispatch_pkg::XLEN-1:0]    mul_issue_op2,
    output logic [rs_dispatch_pkg::PTAG_W-1:0]  mul_issue_rd_tag,
    output logic [rs_dispatch_pkg::INUM_W-1:0]  mul_issue_inst_num,
    output rs_dispatch_pkg::muldiv_ctrl_t       mul_issue_ctrl,
    output logic                                div_issue_valid,
    output logic [rs_dispatch_pkg::XLEN-1:0]    div_issue_op1,
    output logic [rs_dispatch_pkg::XLEN-1:0]    div_issue_op2,
    output logic [rs_dispatch_pkg::PTAG_W-1:0]  div_issue_rd_tag,
    output logic [rs_dispatch_pkg::INUM_W-1:0]  div_issue_inst_num,
    output rs_dispatch_pkg::muldiv_ctrl_t       div_issue_ctrl
);

    rs_dispatch_if #(.PAYLOAD_T(rs_dispatch_pkg::alu_ctrl_t))    add_rs ();
    rs_dispatch_if #(.PAYLOAD_T(rs_dispatch_pkg::muldiv_ctrl_t)) mul_rs ();
    rs_dispatch_if #(.PAYLOAD_T(rs_dispatch_pkg::muldiv_ctrl_t)) div_rs ();

    rs_ex_decoder u_decoder (.*);   // Port names match the top level one to one

    reservation_station #(
        .RS_DEPTH  (RS_DEPTH),
        .PAYLOAD_T (rs_dispatch_pkg::alu_ctrl_t)
    ) u_add_rs (
        .clk            (clk),
        .reset          (reset),
        .disp           (add_rs),
        .res_valid      (res_valid),
        .res_tag        (res_tag),
        .res_value      (res_value),
        .issue_valid    (add_issue_valid),
        .issue_op1      (add_issue_op1),
        .issue_op2      (add_issue_op2),
        .issue_rd_tag   (add_issue_rd_tag),
        .issue_inst_num (add_issue_inst_num),
        .issue_payload  (add_issue_ctrl)
    );

    reservation_station #(
        .RS_DEPTH  (RS_DEPTH),
        .PAYLOAD_T (rs_dispatch_pkg::muldiv_ctrl_t)
    ) u_mul_rs (
        .clk            (clk),
        .reset          (reset),
        .disp           (mul_rs),
        .res_valid      (res_valid),
        .res_tag        (res_tag),
        .res_value      (res_value),
        .issue_valid    (mul_issue_valid),
        .issue_op1      (mul_issue_op1),
        .issue_op2      (mul_issue_op2),
        .issue_rd_tag   (mul_issue_rd_tag),
        .issue_inst_num (mul_issue_inst_num),
        .issue_payload  (mul_issue_ctrl)
    );

    reservation_station #(
        .RS_DEPTH  (RS_DEPTH),
        .PAYLOAD_T (rs_dispatch_pkg::muldiv_ctrl_t)
    ) u_div_rs (
        .clk            (clk),
        .reset          (reset),
        .disp           (div_rs),
        .res_valid      (res_valid),
        .res_tag        (res_tag),
        .res_value      (res_value),
        .issue_valid    (div_issue_valid),
        .issue_op1      (div_issue_op1),
        .issue_op2      (div_issue_op2),
        .issue_rd_tag   (div_issue_rd_tag),
        .issue_inst_num (div_issue_inst_num),
        .issue_payload  (div_issue_ctrl)
    );

endmodule

`default_nettype wire

// File: rtl/rs_ex_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rs_ex_decoder (
    input  wire [6:0]                         in_opcode,
    input  wire [2:0]                         in_func3,
    input  wire [6:0]                         in_funct7,
    input  wire [rs_dispatch_pkg::XLEN-1:0]   in_operand1,
    input  wire [rs_dispatch_pkg::XLEN-1:0]   in_operand2,
    input  wire [rs_dispatch_pkg::XLEN-1:0]   in_pc,
    input  wire [rs_dispatch_pkg::XLEN-1:0]   immediate,
    input  wire [rs_dispatch_pkg::INUM_W-1:0] inst_num,
    input  wire [rs_dispatch_pkg::PTAG_W-1:0] rd_phy_reg,
    input  wire [rs_dispatch_pkg::PTAG_W-1:0] operand1_phy,
    input  wire [rs_dispatch_pkg::PTAG_W-1:0] operand2_phy,
    input  wire [1:0]                         valid,
    input  wire                               mem_to_reg,
    input  wire                               mem_read,
    input  wire                               mem_write,
    input  wire [rs_dispatch_pkg::ALUOP_W-1:0] alu_op,
    input  wire                               alu_src1,
    input  wire                               alu_src2,
    input  wire                               jump,
    input  wire                               branch,
    rs_dispatch_if.decoder                    add_rs,
    rs_dispatch_if.decoder                    mul_rs,
    rs_dispatch_if.decoder                    div_rs,
    output logic                              add_full,
    output logic                              mul_full,
    output logic                              div_full
);

    logic                          is_muldiv;
    logic                          to_mul;
    logic                          to_div;
    logic                          to_add;
    rs_dispatch_pkg::alu_ctrl_t    alu_pkt;
    rs_dispatch_pkg::muldiv_ctrl_t md_pkt;

    assign is_muldiv = (in_opcode == rs_dispatch_pkg::OPC_RTYPE) &&
                       (in_funct7 == rs_dispatch_pkg::FUNCT7_MULDIV);
    assign to_mul    = is_muldiv && (in_func3 == rs_dispatch_pkg::F3_MUL);
    assign to_div    = is_muldiv && (in_func3 == rs_dispatch_pkg::F3_DIV ||
                                     in_func3 == rs_dispatch_pkg::F3_REM);
    // MULH, DIVU, REMU and friends land here too
    assign to_add    = (in_opcode != rs_dispatch_pkg::OPC_NOP) && !to_mul && !to_div;

    always_comb begin
        alu_pkt.func3      = in_func3;
        alu_pkt.pc         = in_pc;
        alu_pkt.immediate  = immediate;
        alu_pkt.mem_to_reg = mem_to_reg;
        alu_pkt.mem_read   = mem_read;
        alu_pkt.mem_write  = mem_write;
        alu_pkt.alu_op     = alu_op;
        alu_pkt.alu_src1   = alu_src1;
        alu_pkt.alu_src2   = alu_src2;
        alu_pkt.jump       = jump;
        alu_pkt.branch     = branch;
        md_pkt.func3       = in_func3;
        md_pkt.pc          = in_pc;
    end

    assign add_rs.on       = to_add;
    assign add_rs.payload  = alu_pkt;
    assign add_rs.src1_val = in_operand1;
    assign add_rs.src2_val = in_operand2;
    assign add_rs.src1_tag = operand1_phy;
    assign add_rs.src2_tag = operand2_phy;
    assign add_rs.src_rdy  = valid;
    assign add_rs.rd_tag   = rd_phy_reg;
    assign add_rs.inst_num = inst_num;

    assign mul_rs.on       = to_mul;
    assign mul_rs.payload  = md_pkt;
    assign mul_rs.src1_val = in_operand1;
    assign mul_rs.src2_val = in_operand2;
    assign mul_rs.src1_tag = operand1_phy;
    assign mul_rs.src2_tag = operand2_phy;
    assign mul_rs.src_rdy  = valid;
    assign mul_rs.rd_tag   = rd_phy_reg;
    assign mul_rs.inst_num = inst_num;

    assign div_rs.on       = to_div;
    assign div_rs.payload  = md_pkt;
    assign div_rs.src1_val = in_operand1;
    assign div_rs.src2_val = in_operand2;
    assign div_rs.src1_tag = operand1_phy;
    assign div_rs.src2_tag = operand2_phy;
    assign div_rs.src_rdy  = valid;
    assign div_rs.rd_tag   = rd_phy_reg;
    assign div_rs.inst_num = inst_num;

    assign add_full = add_rs.full;   // Back-pressure toward rename
    assign mul_full = mul_rs.full;
    assign div_full = div_rs.full;

endmodule

`default_nettype wire

// File: testbench/tb_rs_model.svh
`ifndef TB_RS_MODEL_SVH
`define TB_RS_MODEL_SVH

// Station index 0 add, 1 mul, 2 div, 3 means no station
localparam int MCAP = 32;

bit                         m_busy [3][MCAP];
logic [1:0]                 m_rdy  [3][MCAP];
logic [7:0]                 m_tag1 [3][MCAP];
logic [7:0]                 m_tag2 [3][MCAP];
logic [31:0]                m_val1 [3][MCAP];
logic [31:0]                m_val2 [3][MCAP];
logic [7:0]                 m_rd   [3][MCAP];
logic [31:0]                m_inum [3][MCAP];
int                         m_seq  [3][MCAP];
rs_dispatch_pkg::alu_ctrl_t m_ctrl [3][MCAP];
int                         m_cnt  [3];
int                         m_seq_ctr;
int                         m_dispatched;
int                         m_issued;

function automatic int route_of(logic [6:0] opc, logic [6:0] f7, logic [2:0] f3);
    if (opc == 7'b0000000) return 3;   // Bubble
    if (opc == 7'b0110011 && f7 == 7'b0000001) begin
        if (f3 == 3'b000) return 1;
        if (f3 == 3'b100 || f3 == 3'b110) return 2;
    end
    return 0;
endfunction

task automatic model_dispatch(int s, logic [1:0] rdy, logic [7:0] t1, logic [7:0] t2,
                              logic [31:0] v1, logic [31:0] v2, logic [7:0] rd,
                              logic [31:0] inum, rs_dispatch_pkg::alu_ctrl_t ctrl);
    int i;
    i = 0;
    while (m_busy[s][i]) i++;
    m_busy[s][i] = 1'b1;
    m_rdy[s][i]  = rdy;
    m_tag1[s][i] = t1;
    m_tag2[s][i] = t2;
    m_val1[s][i] = v1;
    m_val2[s][i] = v2;
    m_rd[s][i]   = rd;
    m_inum[s][i] = inum;
    m_ctrl[s][i] = ctrl;
    m_seq[s][i]  = m_seq_ctr;
    m_seq_ctr++;
    m_cnt[s]++;
    m_dispatched++;
endtask

// Missing operands waiting on this tag take the broadcast value
task automatic model_wakeup(logic [7:0] tag, logic [31:0] val);
    for (int s = 0; s < 3; s++) begin
        for (int i = 0; i < MCAP; i++) begin
            if (m_busy[s][i] && !m_rdy[s][i][0] && m_tag1[s][i] == tag) begin
                m_rdy[s][i][0] = 1'b1;
                m_val1[s][i]   = val;
            end
            if (m_busy[s][i] && !m_rdy[s][i][1] && m_tag2[s][i] == tag) begin
                m_rdy[s][i][1] = 1'b1;
                m_val2[s][i]   = val;
            end
        end
    end
endtask

function automatic int find_entry(int s, logic [31:0] inum);
    for (int i = 0; i < MCAP; i++) begin
        if (m_busy[s][i] && m_inum[s][i] == inum) return i;
    end
    return -1;
endfunction

function automatic int oldest_ready(int s);
    int o;
    o = -1;
    for (int i = 0; i < MCAP; i++) begin
        if (m_busy[s][i] && m_rdy[s][i] == 2'b11 && (o < 0 || m_seq[s][i] < m_seq[s][o])) begin
            o = i;
        end
    end
    return o;
endfunction

task automatic model_remove(int s, int i);
    m_busy[s][i] = 1'b0;
    m_cnt[s]--;
    m_issued++;
endtask

`endif

// File: testbench/tb_rs_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rs_dispatch;

    localparam int RS_DEPTH = 8;

    logic clk, reset;
    logic [6:0] in_opcode, in_funct7;
    logic [2:0] in_func3;
    logic [31:0] in_operand1, in_operand2, in_pc, immediate, inst_num;
    logic [7:0] rd_phy_reg, operand1_phy, operand2_phy;
    logic [1:0] valid;
    logic mem_to_reg, mem_read, mem_write, alu_src1, alu_src2, jump, branch;
    logic [3:0] alu_op;
    logic res_valid;
    logic [7:0] res_tag;
    logic [31:0] res_value;
    logic add_full, mul_full, div_full;
    logic add_issue_valid, mul_issue_valid, div_issue_valid;
    logic [31:0] add_issue_op1, add_issue_op2, mul_issue_op1, mul_issue_op2;
    logic [31:0] div_issue_op1, div_issue_op2;
    logic [31:0] add_issue_inst_num, mul_issue_inst_num, div_issue_inst_num;
    logic [7:0] add_issue_rd_tag, mul_issue_rd_tag, div_issue_rd_tag;
    rs_dispatch_pkg::alu_ctrl_t add_issue_ctrl;
    rs_dispatch_pkg::muldiv_ctrl_t mul_issue_ctrl, div_issue_ctrl;

    int seed;
    int errs [1:6];
    int checks;
    logic [7:0] tag_ctr;
    logic [31:0] inum_ctr;
    logic [31:0] base;
    logic [7:0] pool [$];       // Producers still owed a result
    logic [31:0] mul_log [$];
    int sv_route;
    logic [1:0] sv_rdy;
    logic [7:0] sv_t1, sv_t2, sv_rd, sv_res_tag;
    logic [31:0] sv_v1, sv_v2, sv_inum, sv_res_value;
    logic sv_res_valid;
    rs_dispatch_pkg::alu_ctrl_t sv_ctrl;

    `include "tb_rs_model.svh"

    rs_dispatch_top #(.RS_DEPTH(RS_DEPTH)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(int t, string name, logic [127:0] exp, logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errs[t]++;
            $display("FAILED %s: expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic timeout_fail(string what);
        $display("Timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    function automatic int urand(int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    function automatic bit pool_has(logic [7:0] tag);
        foreach (pool[k]) begin
            if (pool[k] == tag) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_issue(int s, string u, logic vld, logic [31:0] inum, logic [7:0] rd,
                               logic [31:0] op1, logic [31:0] op2, logic [2:0] f3,
                               logic [31:0] pc, rs_dispatch_pkg::alu_ctrl_t ctrl);
        int i;
        int o;
        if (vld) begin
            i = find_entry(s, inum);
            check_value(2, {u, " issue matches a pending entry"}, 1, i >= 0);
            if (i >= 0) begin
                o = oldest_ready(s);
                check_value(4, {u, " operands ready"}, 2'b11, m_rdy[s][i]);
                if (o >= 0) check_value(5, {u, " oldest ready"}, m_inum[s][o], inum);
                check_value(3, {u, " rd tag"}, m_rd[s][i], rd);
                check_value(3, {u, " op1"}, m_val1[s][i], op1);
                check_value(3, {u, " op2"}, m_val2[s][i], op2);
                if (s == 0) check_value(3, {u, " ctrl"}, m_ctrl[s][i], ctrl);
                else check_value(3, {u, " func3 and pc"},
                                 {m_ctrl[s][i].func3, m_ctrl[s][i].pc}, {f3, pc});
                model_remove(s, i);
            end
        end
    endtask

    // Issue of edge E is checked against the model before edge E's inputs are applied
    always @(negedge clk) begin
        if (!reset) begin
            check_issue(0, "add", add_issue_valid, add_issue_inst_num, add_issue_rd_tag,
                        add_issue_op1, add_issue_op2, add_issue_ctrl.func3, add_issue_ctrl.pc,
                        add_issue_ctrl);
            check_issue(1, "mul", mul_issue_valid, mul_issue_inst_num, mul_issue_rd_tag,
                        mul_issue_op1, mul_issue_op2, mul_issue_ctrl.func3, mul_issue_ctrl.pc, '0);
            check_issue(2, "div", div_issue_valid, div_issue_inst_num, div_issue_rd_tag,
                        div_issue_op1, div_issue_op2, div_issue_ctrl.func3, div_issue_ctrl.pc, '0);
            if (mul_issue_valid) mul_log.push_back(mul_issue_inst_num);
            if (sv_route < 3) model_dispatch(sv_route, sv_rdy, sv_t1, sv_t2, sv_v1, sv_v2,
                                             sv_rd, sv_inum, sv_ctrl);
            if (sv_res_valid) model_wakeup(sv_res_tag, sv_res_value);
        end
        sv_route     = route_of(in_opcode, in_funct7, in_func3);
        sv_rdy       = valid;
        sv_t1        = operand1_phy;
        sv_t2        = operand2_phy;
        sv_v1        = in_operand1;
        sv_v2        = in_operand2;
        sv_rd        = rd_phy_reg;
        sv_inum      = inst_num;
        sv_ctrl      = {in_func3, in_pc, immediate, mem_to_reg, mem_read, mem_write, alu_op,
                        alu_src1, alu_src2, jump, branch};
        sv_res_valid = res_valid;
        sv_res_tag   = res_tag;
        sv_res_value = res_value;
    end

    task automatic drive_inst(logic [6:0] opc, logic [6:0] f7, logic [2:0] f3, logic [1:0] rdy,
                              logic [7:0] t1, logic [7:0] t2);
        logic [31:0] r;
        r = $random(seed);
        in_opcode    <= opc;
        in_funct7    <= f7;
        in_func3     <= f3;
        valid        <= rdy;
        operand1_phy <= t1;
        operand2_phy <= t2;
        in_operand1  <= $random(seed);
        in_operand2  <= $random(seed);
        in_pc        <= $random(seed);
        immediate    <= $random(seed);
        {mem_to_reg, mem_read, mem_write, alu_op, alu_src1, alu_src2, jump, branch} <= r[10:0];
        rd_phy_reg   <= tag_ctr;
        inst_num     <= inum_ctr;
        if (route_of(opc, f7, f3) < 3) begin
            tag_ctr++;
            inum_ctr++;
        end
    endtask

    task automatic random_cycle();
        int idx;
        int kind;
        int s;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [1:0] rdy;
        logic [7:0] t1;
        logic [7:0] t2;
        res_valid <= 1'b0;
        if (pool.size() > 0 && urand(100) < 35) begin
            idx = urand(pool.size());
            res_valid <= 1'b1;
            res_tag   <= pool[idx];
            res_value <= $random(seed);
            pool.delete(idx);
        end
        kind = urand(10);
        opc  = 7'b0110011;
        f7   = 7'd1;
        f3   = 3'($random(seed));
        if (kind < 2) opc = 7'd0;
        else if (kind == 2) f3 = 3'b000;
        else if (kind == 3) f3 = 3'b100;
        else if (kind == 4) f3 = 3'b110;
        else if (kind < 7) f7 = (kind == 5) ? 7'h00 : 7'h20;
        else opc = 7'($random(seed));
        s = route_of(opc, f7, f3);
        if (s < 3 && m_cnt[s] + ((sv_route == s) ? 1 : 0) >= RS_DEPTH) opc = 7'd0;
        rdy = 2'b11;
        t1  = 8'($random(seed));
        t2  = 8'($random(seed));
        if (pool.size() > 0 && urand(2) == 0) begin
            rdy[0] = 1'b0;
            t1     = pool[urand(pool.size())];
        end
        if (pool.size() > 0 && urand(2) == 0) begin
            rdy[1] = 1'b0;
            t2     = pool[urand(pool.size())];
        end
        if (route_of(opc, f7, f3) < 3 && !pool_has(tag_ctr)) pool.push_back(tag_ctr);
        drive_inst(opc, f7, f3, rdy, t1, t2);
    endtask

    task automatic wait_model_empty(int limit);
        int n;
        n = 0;
        while (m_cnt[0] + m_cnt[1] + m_cnt[2] > 0) begin
            @(negedge clk);
            n++;
            if (n > limit) timeout_fail("the stations to drain");
        end
    endtask

    task automatic wait_mul_issues(int count);
        int n;
        n = 0;
        while (mul_log.size() < count) begin
            @(negedge clk);
            n++;
            if (n > 50) timeout_fail("the mul issues");
        end
    endtask

    // Replays every owed result, then lets the stations empty
    task automatic drain();
        while (pool.size() > 0) begin
            @(posedge clk);
            in_opcode <= 7'd0;
            res_valid <= 1'b1;
            res_tag   <= pool[0];
            res_value <= $random(seed);
            pool.delete(0);
        end
        @(posedge clk);
        in_opcode <= 7'd0;
        res_valid <= 1'b0;
        repeat (2) @(negedge clk);
        wait_model_empty(100);
    endtask

    task automatic report(int t, string name);
        $display("test %0d %s: %0d errors", t, name, errs[t]);
    endtask

    initial begin
        int n;
        int total;
        seed = 32'h5e9d25c5;
        tag_ctr  = 8'd0;
        inum_ctr = 32'd0;
        reset = 1'b1;
        drive_inst(7'd0, 7'd0, 3'd0, 2'b00, 8'd0, 8'd0);
        res_valid = 1'b0;
        res_tag   = 8'd0;
        res_value = 32'd0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        repeat (10) begin
            @(negedge clk);
            check_value(1, "reset idle", 0, {add_issue_valid, mul_issue_valid, div_issue_valid,
                                             add_full, mul_full, div_full});
        end
        report(1, "reset");

        repeat (400) begin
            @(posedge clk);
            random_cycle();
        end
        drain();
        check_value(4, "issued count", m_dispatched, m_issued);
        report(2, "routing");
        report(3, "payload and operands");
        report(4, "readiness");

        // Younger entries refill the low slots, so slot order differs from age order
        mul_log.delete();
        base = inum_ctr;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            drive_inst(7'b0110011, 7'd1, 3'b000, 2'b10, 8'(240 + i / 4), 8'd0);
        end
        @(posedge clk);
        in_opcode <= 7'd0;
        res_valid <= 1'b1;
        res_tag   <= 8'd240;
        res_value <= $random(seed);
        @(posedge clk);
        res_valid <= 1'b0;
        wait_mul_issues(4);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            drive_inst(7'b0110011, 7'd1, 3'b000, 2'b10, 8'd242, 8'd0);
        end
        @(posedge clk);
        in_opcode <= 7'd0;
        res_valid <= 1'b1;
        res_tag   <= 8'd241;
        res_value <= $random(seed);
        @(posedge clk);
        res_tag   <= 8'd242;
        res_value <= $random(seed);
        @(posedge clk);
        res_valid <= 1'b0;
        wait_mul_issues(12);
        for (int k = 0; k < 12; k++) check_value(5, "mul issue order", base + k, mul_log[k]);
        report(5, "age order");

        for (int i = 0; i < RS_DEPTH; i++) begin
            @(posedge clk);
            drive_inst(7'b0110011, 7'd1, 3'b100, 2'b10, 8'(200 + i), 8'd0);
        end
        @(posedge clk);
        in_opcode <= 7'd0;
        repeat (2) @(negedge clk);
        check_value(6, "full levels", 3'b001, {add_full, mul_full, div_full});
        @(posedge clk);
        res_valid <= 1'b1;
        res_tag   <= 8'd200;
        res_value <= $random(seed);
        @(posedge clk);
        res_valid <= 1'b0;
        n = 0;
        while (div_full) begin
            @(negedge clk);
            n++;
            if (n > 20) timeout_fail("div full to clear");
        end
        for (int i = 1; i < RS_DEPTH; i++) pool.push_back(8'(200 + i));
        drain();
        check_value(6, "issued count", m_dispatched, m_issued);
        report(6, "full level");

        total = errs[1] + errs[2] + errs[3] + errs[4] + errs[5] + errs[6];
        $display("checks %0d, errors %0d", checks, total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
